// File: source/rv_ctrl_pkg.sv
//----------------------------------------------------------
// shared types for the RV32I pipeline control unit
// opcodes, ALU and compare ops, mux selects, control words
// import with rv_ctrl_pkg::* in each module header
//----------------------------------------------------------
package rv_ctrl_pkg;

    // instruction field widths
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int OPCODE_W   = 7;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [FUNCT3_W-1:0]   funct3_t;
    typedef logic [FUNCT7_W-1:0]   funct7_t;

    // RV32I major opcodes, bits [6:0] of the instruction
    typedef enum logic [OPCODE_W-1:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // arithmetic funct3 codes, shared by op_imm and op_reg
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // load width funct3 codes
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    typedef enum logic [2:0] {
        alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
    } alu_op_t;

    // values equal the branch funct3 field
    typedef enum logic [FUNCT3_W-1:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    // mux selects, literals carry the mux name
    typedef enum logic {alumux1_rs1_out, alumux1_pc_out} alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm, alumux2_u_imm, alumux2_b_imm,
        alumux2_s_imm, alumux2_j_imm, alumux2_rs2_out
    } alumux2_sel_t;

    typedef enum logic {cmpmux_rs2_out, cmpmux_i_imm} cmpmux_sel_t;

    typedef enum logic [3:0] {
        rfmux_alu_out, rfmux_br_en, rfmux_u_imm, rfmux_lw, rfmux_pc_plus4,
        rfmux_lb, rfmux_lbu, rfmux_lh, rfmux_lhu
    } regfilemux_sel_t;

    // control transfer kind, resolved to a PC select in execute
    typedef enum logic [1:0] {pc_seq, pc_jal, pc_jalr, pc_branch} pc_kind_t;

    typedef enum logic [1:0] {pcmux_pc_plus4, pcmux_alu_out, pcmux_alu_mod2} pcmux_sel_t;

    typedef struct packed {
        alu_op_t      aluop;
        alumux1_sel_t alumux1_sel;
        alumux2_sel_t alumux2_sel;
        cmp_op_t      cmpop;
        cmpmux_sel_t  cmp_sel;
        pc_kind_t     pc_kind;
    } cw_exe_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
    } cw_mem_t;

    typedef struct packed {
        logic            ld_reg;
        regfilemux_sel_t regfilemux_sel;
        reg_addr_t       rd;
    } cw_wb_t;

    // default words, also the reset value of the stage registers
    localparam cw_exe_t CW_EXE_DEFAULT = '{
        aluop:       alu_add,
        alumux1_sel: alumux1_rs1_out,
        alumux2_sel: alumux2_i_imm,
        cmpop:       beq,
        cmp_sel:     cmpmux_rs2_out,
        pc_kind:     pc_seq
    };
    localparam cw_mem_t CW_MEM_DEFAULT = '{mem_read: 1'b0, mem_write: 1'b0};
    localparam cw_wb_t  CW_WB_DEFAULT  = '{
        ld_reg:         1'b0,
        regfilemux_sel: rfmux_alu_out,
        rd:             '0
    };

endpackage

// File: source/ctrl_word_if.sv
//----------------------------------------------------------
// decoded control words, decoder to stage pipeline
// decoder drives all three words every cycle
// stage side samples them when the de/exe register loads
//----------------------------------------------------------
`timescale 1ns/10ps

interface ctrl_word_if
    import rv_ctrl_pkg::*;
();

    cw_exe_t cw_exe;
    cw_mem_t cw_mem;
    cw_wb_t  cw_wb;

    // producer side
    modport decoder (
        output cw_exe, cw_mem, cw_wb
    );

    // consumer side
    modport stage (
        input cw_exe, cw_mem, cw_wb
    );

endinterface

// File: source/instr_decoder.sv
//----------------------------------------------------------
// combinational RV32I decode for the instruction in decode
// builds the execute, memory and writeback control words
// unknown opcodes give the default words
//----------------------------------------------------------
`timescale 1ns/10ps

module instr_decoder
    import rv_ctrl_pkg::*;
(
    input  opcode_t   i_opcode,
    input  funct3_t   i_funct3,
    input  funct7_t   i_funct7,
    input  reg_addr_t i_rd,
    ctrl_word_if.decoder cw
);

    cw_exe_t exe_w;
    cw_mem_t mem_w;
    cw_wb_t  wb_w;
    logic    is_imm;

    // op_imm takes the immediate and op_reg takes rs2
    assign is_imm = (i_opcode == op_imm);

    always_comb begin
        exe_w = CW_EXE_DEFAULT;
        mem_w = CW_MEM_DEFAULT;
        wb_w  = CW_WB_DEFAULT;
        // destination always travels and ld_reg decides the write
        wb_w.rd = i_rd;

        case (i_opcode)
            op_lui: begin
                wb_w.ld_reg         = 1'b1;
                wb_w.regfilemux_sel = rfmux_u_imm;
            end
            op_auipc: begin
                exe_w.alumux1_sel   = alumux1_pc_out;
                exe_w.alumux2_sel   = alumux2_u_imm;
                wb_w.ld_reg         = 1'b1;
            end
            op_jal: begin
                // target is pc + j_imm and the link is pc + 4
                exe_w.alumux1_sel   = alumux1_pc_out;
                exe_w.alumux2_sel   = alumux2_j_imm;
                exe_w.pc_kind       = pc_jal;
                wb_w.ld_reg         = 1'b1;
                wb_w.regfilemux_sel = rfmux_pc_plus4;
            end
            op_jalr: begin
                // target rs1 + i_imm with lsb cleared later by the PC mux
                exe_w.pc_kind       = pc_jalr;
                wb_w.ld_reg         = 1'b1;
                wb_w.regfilemux_sel = rfmux_pc_plus4;
            end
            op_br: begin
                exe_w.alumux1_sel = alumux1_pc_out;
                exe_w.alumux2_sel = alumux2_b_imm;
                exe_w.pc_kind     = pc_branch;
                // funct3 is the compare op and reserved codes stay beq
                case (i_funct3)
                    3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111:
                        exe_w.cmpop = cmp_op_t'(i_funct3);
                    default: exe_w.cmpop = beq;
                endcase
            end
            op_load: begin
                mem_w.mem_read = 1'b1;
                wb_w.ld_reg    = 1'b1;
                case (i_funct3)
                    F3_LB:   wb_w.regfilemux_sel = rfmux_lb;
                    F3_LH:   wb_w.regfilemux_sel = rfmux_lh;
                    F3_LW:   wb_w.regfilemux_sel = rfmux_lw;
                    F3_LBU:  wb_w.regfilemux_sel = rfmux_lbu;
                    F3_LHU:  wb_w.regfilemux_sel = rfmux_lhu;
                    default: wb_w.regfilemux_sel = rfmux_alu_out;
                endcase
            end
            op_store: begin
                exe_w.alumux2_sel = alumux2_s_imm;
                mem_w.mem_write   = 1'b1;
            end
            op_imm, op_reg: begin
                wb_w.ld_reg       = 1'b1;
                exe_w.alumux2_sel = is_imm ? alumux2_i_imm : alumux2_rs2_out;
                case (i_funct3)
                    F3_ADD: begin
                        // sub only exists in op_reg
                        if (!is_imm && i_funct7[5]) begin
                            exe_w.aluop = alu_sub;
                        end
                    end
                    F3_SLL: exe_w.aluop = alu_sll;
                    F3_SLT: begin
                        exe_w.cmpop         = blt;
                        exe_w.cmp_sel       = is_imm ? cmpmux_i_imm : cmpmux_rs2_out;
                        wb_w.regfilemux_sel = rfmux_br_en;
                    end
                    F3_SLTU: begin
                        exe_w.cmpop         = bltu;
                        exe_w.cmp_sel       = is_imm ? cmpmux_i_imm : cmpmux_rs2_out;
                        wb_w.regfilemux_sel = rfmux_br_en;
                    end
                    F3_XOR: exe_w.aluop = alu_xor;
                    // funct7 bit 5 picks arithmetic shift
                    F3_SR:  exe_w.aluop = i_funct7[5] ? alu_sra : alu_srl;
                    F3_OR:  exe_w.aluop = alu_or;
                    F3_AND: exe_w.aluop = alu_and;
                    default: exe_w.aluop = alu_add;
                endcase
            end
            default: begin
                // unknown opcode keeps the default words
            end
        endcase
    end

    assign cw.cw_exe = exe_w;
    assign cw.cw_mem = mem_w;
    assign cw.cw_wb  = wb_w;

endmodule

// File: source/stage_ctrl.sv
//----------------------------------------------------------
// stall logic and control-word stage registers
// a stage stalls when valid and not ready, which freezes it
// and everything upstream; next-PC select comes from exe
//----------------------------------------------------------
`timescale 1ns/10ps

module stage_ctrl
    import rv_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    ctrl_word_if.stage cw,
    input  logic       i_de_valid,
    input  logic       i_de_rdy,
    input  logic       i_exe_rdy,
    input  logic       i_mem_rdy,
    input  logic       i_wb_rdy,
    input  logic       i_br_en,
    output logic       o_if_de_ld,
    output logic       o_de_exe_ld,
    output logic       o_exe_mem_ld,
    output logic       o_mem_wb_ld,
    output logic       o_exe_valid,
    output logic       o_mem_valid,
    output logic       o_wb_valid,
    output cw_exe_t    o_cw_exe,
    output cw_mem_t    o_cw_mem,
    output cw_wb_t     o_cw_wb,
    output pcmux_sel_t o_pcmux_sel
);

    logic    de_stall, exe_stall, mem_stall, wb_stall;
    logic    exe_valid, mem_valid, wb_valid;
    // exe register holds all three words, mem holds two, wb one
    cw_exe_t exe_cw_exe;
    cw_mem_t exe_cw_mem, mem_cw_mem;
    cw_wb_t  exe_cw_wb, mem_cw_wb, wb_cw_wb;

    assign de_stall  = i_de_valid && !i_de_rdy;
    assign exe_stall = exe_valid && !i_exe_rdy;
    assign mem_stall = mem_valid && !i_mem_rdy;
    assign wb_stall  = wb_valid && !i_wb_rdy;

    // a register loads only if nothing from its next stage on stalls
    assign o_mem_wb_ld  = !rst && !wb_stall;
    assign o_exe_mem_ld = !rst && !mem_stall && !wb_stall;
    assign o_de_exe_ld  = !rst && !exe_stall && !mem_stall && !wb_stall;
    assign o_if_de_ld   = !rst && !de_stall && !exe_stall && !mem_stall && !wb_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_valid  <= 1'b0;
            mem_valid  <= 1'b0;
            wb_valid   <= 1'b0;
            exe_cw_exe <= CW_EXE_DEFAULT;
            exe_cw_mem <= CW_MEM_DEFAULT;
            exe_cw_wb  <= CW_WB_DEFAULT;
            mem_cw_mem <= CW_MEM_DEFAULT;
            mem_cw_wb  <= CW_WB_DEFAULT;
            wb_cw_wb   <= CW_WB_DEFAULT;
        end else begin
            // a not-ready stage hands on a bubble
            if (o_de_exe_ld) begin
                exe_valid  <= i_de_valid && i_de_rdy;
                exe_cw_exe <= cw.cw_exe;
                exe_cw_mem <= cw.cw_mem;
                exe_cw_wb  <= cw.cw_wb;
            end
            if (o_exe_mem_ld) begin
                mem_valid  <= exe_valid && i_exe_rdy;
                mem_cw_mem <= exe_cw_mem;
                mem_cw_wb  <= exe_cw_wb;
            end
            if (o_mem_wb_ld) begin
                wb_valid <= mem_valid && i_mem_rdy;
                wb_cw_wb <= mem_cw_wb;
            end
        end
    end

    // next PC, only a valid exe stage redirects fetch
    always_comb begin
        o_pcmux_sel = pcmux_pc_plus4;
        if (exe_valid) begin
            case (exe_cw_exe.pc_kind)
                pc_jal:    o_pcmux_sel = pcmux_alu_out;
                pc_jalr:   o_pcmux_sel = pcmux_alu_mod2;
                pc_branch: o_pcmux_sel = i_br_en ? pcmux_alu_out : pcmux_pc_plus4;
                default:   o_pcmux_sel = pcmux_pc_plus4;
            endcase
        end
    end

    assign o_exe_valid = exe_valid;
    assign o_mem_valid = mem_valid;
    assign o_wb_valid  = wb_valid;
    assign o_cw_exe    = exe_cw_exe;
    assign o_cw_mem    = mem_cw_mem;
    assign o_cw_wb     = wb_cw_wb;

endmodule

// File: source/pipe_ctrl_top.sv
//----------------------------------------------------------
// control unit top, decoder feeding the stage registers
// all stage handshakes and control words on plain ports
//----------------------------------------------------------
`timescale 1ns/10ps

module pipe_ctrl_top
    import rv_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  opcode_t    i_opcode,
    input  funct3_t    i_funct3,
    input  funct7_t    i_funct7,
    input  reg_addr_t  i_rd,
    input  logic       i_de_valid,
    input  logic       i_de_rdy,
    input  logic       i_exe_rdy,
    input  logic       i_mem_rdy,
    input  logic       i_wb_rdy,
    input  logic       i_br_en,
    output logic       o_if_de_ld,
    output logic       o_de_exe_ld,
    output logic       o_exe_mem_ld,
    output logic       o_mem_wb_ld,
    output logic       o_exe_valid,
    output logic       o_mem_valid,
    output logic       o_wb_valid,
    output cw_exe_t    o_cw_exe,
    output cw_mem_t    o_cw_mem,
    output cw_wb_t     o_cw_wb,
    output pcmux_sel_t o_pcmux_sel
);

    // decoded words of the instruction in decode
    ctrl_word_if cw_bus ();

    instr_decoder u_decoder (
        .i_opcode (i_opcode),
        .i_funct3 (i_funct3),
        .i_funct7 (i_funct7),
        .i_rd     (i_rd),
        .cw       (cw_bus.decoder)
    );

    stage_ctrl u_stage (
        .clk          (clk),
        .rst          (rst),
        .cw           (cw_bus.stage),
        .i_de_valid   (i_de_valid),
        .i_de_rdy     (i_de_rdy),
        .i_exe_rdy    (i_exe_rdy),
        .i_mem_rdy    (i_mem_rdy),
        .i_wb_rdy     (i_wb_rdy),
        .i_br_en      (i_br_en),
        .o_if_de_ld   (o_if_de_ld),
        .o_de_exe_ld  (o_de_exe_ld),
        .o_exe_mem_ld (o_exe_mem_ld),
        .o_mem_wb_ld  (o_mem_wb_ld),
        .o_exe_valid  (o_exe_valid),
        .o_mem_valid  (o_mem_valid),
        .o_wb_valid   (o_wb_valid),
        .o_cw_exe     (o_cw_exe),
        .o_cw_mem     (o_cw_mem),
        .o_cw_wb      (o_cw_wb),
        .o_pcmux_sel  (o_pcmux_sel)
    );

endmodule

// File: verification/pipe_ctrl_sva.sv
//----------------------------------------------------------
// concurrent checks on the stall and valid rules
// bound into stage_ctrl, watches load enables and valids
//----------------------------------------------------------
`timescale 1ns/10ps

module pipe_ctrl_sva
    import rv_ctrl_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    i_de_valid,
    input logic    i_de_rdy,
    input logic    i_exe_rdy,
    input logic    i_mem_rdy,
    input logic    i_wb_rdy,
    input logic    o_if_de_ld,
    input logic    o_de_exe_ld,
    input logic    o_exe_mem_ld,
    input logic    o_mem_wb_ld,
    input logic    o_exe_valid,
    input logic    o_mem_valid,
    input logic    o_wb_valid,
    input cw_exe_t o_cw_exe,
    input cw_mem_t o_cw_mem,
    input cw_wb_t  o_cw_wb
);

    logic de_stall;
    logic exe_stall;
    logic mem_stall;
    logic wb_stall;
    logic any_ld;

    // stalled means valid but not ready
    assign de_stall  = i_de_valid && !i_de_rdy;
    assign exe_stall = o_exe_valid && !i_exe_rdy;
    assign mem_stall = o_mem_valid && !i_mem_rdy;
    assign wb_stall  = o_wb_valid && !i_wb_rdy;
    assign any_ld    = o_if_de_ld || o_de_exe_ld || o_exe_mem_ld || o_mem_wb_ld;

    a_rst_loads: assert property (@(posedge clk) rst |-> !any_ld)
        else $error("load enable high during reset");

    // wb stall freezes the whole chain
    a_wb_stall: assert property (@(posedge clk) disable iff (rst) wb_stall |-> !any_ld)
        else $error("load enable high while wb stalled");

    a_mem_stall: assert property (@(posedge clk) disable iff (rst)
        mem_stall && !wb_stall |-> !o_if_de_ld && !o_de_exe_ld && !o_exe_mem_ld && o_mem_wb_ld)
        else $error("wrong load enables while mem stalled");

    // not-ready mem hands a bubble to wb
    a_mem_bubble: assert property (@(posedge clk) disable iff (rst)
        mem_stall && o_mem_wb_ld |=> !o_wb_valid)
        else $error("wb valid after a mem stall");

    a_exe_stall: assert property (@(posedge clk) disable iff (rst)
        exe_stall && !mem_stall && !wb_stall
        |-> !o_if_de_ld && !o_de_exe_ld && o_exe_mem_ld && o_mem_wb_ld)
        else $error("wrong load enables while exe stalled");

    a_de_stall: assert property (@(posedge clk) disable iff (rst) de_stall |-> !o_if_de_ld)
        else $error("if/de load high while decode stalled");

    a_de_bubble: assert property (@(posedge clk) disable iff (rst)
        de_stall && o_de_exe_ld |=> !o_exe_valid)
        else $error("exe valid after a decode stall");

    // frozen registers hold their word and valid
    a_exe_frozen: assert property (@(posedge clk) disable iff (rst)
        !o_de_exe_ld |=> $stable(o_exe_valid) && $stable(o_cw_exe))
        else $error("exe stage changed without a load");

    a_mem_frozen: assert property (@(posedge clk) disable iff (rst)
        !o_exe_mem_ld |=> $stable(o_mem_valid) && $stable(o_cw_mem))
        else $error("mem stage changed without a load");

    a_wb_frozen: assert property (@(posedge clk) disable iff (rst)
        !o_mem_wb_ld |=> $stable(o_wb_valid) && $stable(o_cw_wb))
        else $error("wb stage changed without a load");

endmodule

bind stage_ctrl pipe_ctrl_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .i_de_valid   (i_de_valid),
    .i_de_rdy     (i_de_rdy),
    .i_exe_rdy    (i_exe_rdy),
    .i_mem_rdy    (i_mem_rdy),
    .i_wb_rdy     (i_wb_rdy),
    .o_if_de_ld   (o_if_de_ld),
    .o_de_exe_ld  (o_de_exe_ld),
    .o_exe_mem_ld (o_exe_mem_ld),
    .o_mem_wb_ld  (o_mem_wb_ld),
    .o_exe_valid  (o_exe_valid),
    .o_mem_valid  (o_mem_valid),
    .o_wb_valid   (o_wb_valid),
    .o_cw_exe     (o_cw_exe),
    .o_cw_mem     (o_cw_mem),
    .o_cw_wb      (o_cw_wb)
);

// File: verification/pipe_ctrl_tb.sv
//----------------------------------------------------------
// testbench for the pipeline control unit
// directed decode sweep, stall cases, next-PC cases and
// random traffic, checked against a decode and stage model
//----------------------------------------------------------
`timescale 1ns/10ps

module pipe_ctrl_tb
    import rv_ctrl_pkg::*;
();

    localparam int RAND_CYCLES = 400;
    localparam int FILL_LIMIT  = 20;

    logic       clk;
    logic       rst;
    opcode_t    opcode;
    funct3_t    funct3;
    funct7_t    funct7;
    reg_addr_t  rd;
    logic       de_valid;
    logic       de_rdy;
    logic       exe_rdy;
    logic       mem_rdy;
    logic       wb_rdy;
    logic       br_en;
    logic       if_de_ld;
    logic       de_exe_ld;
    logic       exe_mem_ld;
    logic       mem_wb_ld;
    logic       exe_valid;
    logic       mem_valid;
    logic       wb_valid;
    cw_exe_t    cw_exe;
    cw_mem_t    cw_mem;
    cw_wb_t     cw_wb;
    pcmux_sel_t pcmux_sel;

    // shadow pipeline with one entry per stage register
    logic    m_exe_v;
    logic    m_mem_v;
    logic    m_wb_v;
    cw_exe_t m_exe_e;
    cw_mem_t m_exe_m;
    cw_mem_t m_mem_m;
    cw_wb_t  m_exe_w;
    cw_wb_t  m_mem_w;
    cw_wb_t  m_wb_w;

    logic    run_ok;
    logic    fail_shown;
    opcode_t legal_ops [9];

    pipe_ctrl_top dut (
        .clk          (clk),
        .rst          (rst),
        .i_opcode     (opcode),
        .i_funct3     (funct3),
        .i_funct7     (funct7),
        .i_rd         (rd),
        .i_de_valid   (de_valid),
        .i_de_rdy     (de_rdy),
        .i_exe_rdy    (exe_rdy),
        .i_mem_rdy    (mem_rdy),
        .i_wb_rdy     (wb_rdy),
        .i_br_en      (br_en),
        .o_if_de_ld   (if_de_ld),
        .o_de_exe_ld  (de_exe_ld),
        .o_exe_mem_ld (exe_mem_ld),
        .o_mem_wb_ld  (mem_wb_ld),
        .o_exe_valid  (exe_valid),
        .o_mem_valid  (mem_valid),
        .o_wb_valid   (wb_valid),
        .o_cw_exe     (cw_exe),
        .o_cw_mem     (cw_mem),
        .o_cw_wb      (cw_wb),
        .o_pcmux_sel  (pcmux_sel)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic void show_fail();
        if (!fail_shown) begin
            fail_shown = 1'b1;
            $display("Simulation failed");
        end
    endfunction

    task automatic error_out(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        show_fail();
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic default_words(output cw_exe_t e, output cw_mem_t m, output cw_wb_t w);
        e = '{aluop: alu_add, alumux1_sel: alumux1_rs1_out, alumux2_sel: alumux2_i_imm,
              cmpop: beq, cmp_sel: cmpmux_rs2_out, pc_kind: pc_seq};
        m = '{mem_read: 1'b0, mem_write: 1'b0};
        w = '{ld_reg: 1'b0, regfilemux_sel: rfmux_alu_out, rd: '0};
    endtask

    // expected decode of one instruction
    task automatic ref_decode(input opcode_t op, input funct3_t f3, input funct7_t f7,
                              input reg_addr_t r, output cw_exe_t e, output cw_mem_t m,
                              output cw_wb_t w);
        logic imm;
        default_words(e, m, w);
        w.rd = r;
        imm = (op == op_imm);
        case (op)
            op_lui: begin
                w.ld_reg         = 1'b1;
                w.regfilemux_sel = rfmux_u_imm;
            end
            op_auipc: begin
                e.alumux1_sel = alumux1_pc_out;
                e.alumux2_sel = alumux2_u_imm;
                w.ld_reg      = 1'b1;
            end
            op_jal: begin
                e.alumux1_sel    = alumux1_pc_out;
                e.alumux2_sel    = alumux2_j_imm;
                e.pc_kind        = pc_jal;
                w.ld_reg         = 1'b1;
                w.regfilemux_sel = rfmux_pc_plus4;
            end
            op_jalr: begin
                e.pc_kind        = pc_jalr;
                w.ld_reg         = 1'b1;
                w.regfilemux_sel = rfmux_pc_plus4;
            end
            op_br: begin
                e.alumux1_sel = alumux1_pc_out;
                e.alumux2_sel = alumux2_b_imm;
                e.pc_kind     = pc_branch;
                // 010 and 011 are not branch codes
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    e.cmpop = cmp_op_t'(f3);
                end
            end
            op_load: begin
                m.mem_read = 1'b1;
                w.ld_reg   = 1'b1;
                case (f3)
                    3'd0:    w.regfilemux_sel = rfmux_lb;
                    3'd1:    w.regfilemux_sel = rfmux_lh;
                    3'd2:    w.regfilemux_sel = rfmux_lw;
                    3'd4:    w.regfilemux_sel = rfmux_lbu;
                    3'd5:    w.regfilemux_sel = rfmux_lhu;
                    default: w.regfilemux_sel = rfmux_alu_out;
                endcase
            end
            op_store: begin
                e.alumux2_sel = alumux2_s_imm;
                m.mem_write   = 1'b1;
            end
            op_imm, op_reg: begin
                w.ld_reg      = 1'b1;
                e.alumux2_sel = imm ? alumux2_i_imm : alumux2_rs2_out;
                case (f3)
                    3'd0: e.aluop = (!imm && f7[5]) ? alu_sub : alu_add;
                    3'd1: e.aluop = alu_sll;
                    3'd2: begin
                        e.cmpop          = blt;
                        e.cmp_sel        = imm ? cmpmux_i_imm : cmpmux_rs2_out;
                        w.regfilemux_sel = rfmux_br_en;
                    end
                    3'd3: begin
                        e.cmpop          = bltu;
                        e.cmp_sel        = imm ? cmpmux_i_imm : cmpmux_rs2_out;
                        w.regfilemux_sel = rfmux_br_en;
                    end
                    3'd4: e.aluop = alu_xor;
                    3'd5: e.aluop = f7[5] ? alu_sra : alu_srl;
                    3'd6: e.aluop = alu_or;
                    default: e.aluop = alu_and;
                endcase
            end
            default: begin
                // unknown opcode keeps the default words
            end
        endcase
    endtask

    // expected {if_de, de_exe, exe_mem, mem_wb}
    function automatic logic [3:0] exp_loads();
        logic s_de;
        logic s_exe;
        logic s_mem;
        logic s_wb;
        s_de  = de_valid && !de_rdy;
        s_exe = m_exe_v && !exe_rdy;
        s_mem = m_mem_v && !mem_rdy;
        s_wb  = m_wb_v && !wb_rdy;
        if (rst) begin
            return 4'b0000;
        end
        return {!(s_de || s_exe || s_mem || s_wb), !(s_exe || s_mem || s_wb),
                !(s_mem || s_wb), !s_wb};
    endfunction

    function automatic pcmux_sel_t exp_pcmux();
        pcmux_sel_t sel;
        sel = pcmux_pc_plus4;
        if (m_exe_v && m_exe_e.pc_kind == pc_jal) begin
            sel = pcmux_alu_out;
        end else if (m_exe_v && m_exe_e.pc_kind == pc_jalr) begin
            sel = pcmux_alu_mod2;
        end else if (m_exe_v && m_exe_e.pc_kind == pc_branch && br_en) begin
            sel = pcmux_alu_out;
        end
        return sel;
    endfunction

    task automatic check_outputs();
        logic [3:0] ld;
        ld = exp_loads();
        assert ({if_de_ld, de_exe_ld, exe_mem_ld, mem_wb_ld} == ld)
            else error_out($sformatf("load enables %b, expected %b",
                           {if_de_ld, de_exe_ld, exe_mem_ld, mem_wb_ld}, ld));
        if (!rst) begin
            assert ({exe_valid, mem_valid, wb_valid} == {m_exe_v, m_mem_v, m_wb_v})
                else error_out($sformatf("valids %b, expected %b",
                               {exe_valid, mem_valid, wb_valid}, {m_exe_v, m_mem_v, m_wb_v}));
            assert (cw_exe == m_exe_e)
                else error_out($sformatf("o_cw_exe %h, expected %h", cw_exe, m_exe_e));
            assert (cw_mem == m_mem_m)
                else error_out($sformatf("o_cw_mem %h, expected %h", cw_mem, m_mem_m));
            assert (cw_wb == m_wb_w)
                else error_out($sformatf("o_cw_wb %h, expected %h", cw_wb, m_wb_w));
            assert (pcmux_sel == exp_pcmux())
                else error_out($sformatf("o_pcmux_sel %0d, expected %0d", pcmux_sel,
                               exp_pcmux()));
        end
    endtask

    // advance the shadow pipeline at a rising edge
    task automatic update_model();
        logic [3:0] ld;
        ld = exp_loads();
        if (rst) begin
            default_words(m_exe_e, m_exe_m, m_exe_w);
            m_mem_m = m_exe_m;
            m_mem_w = m_exe_w;
            m_wb_w  = m_exe_w;
            m_exe_v = 1'b0;
            m_mem_v = 1'b0;
            m_wb_v  = 1'b0;
        end else begin
            // downstream first so each stage takes the old upstream word
            if (ld[0]) begin
                m_wb_v = m_mem_v && mem_rdy;
                m_wb_w = m_mem_w;
            end
            if (ld[1]) begin
                m_mem_v = m_exe_v && exe_rdy;
                m_mem_m = m_exe_m;
                m_mem_w = m_exe_w;
            end
            if (ld[2]) begin
                m_exe_v = de_valid && de_rdy;
                ref_decode(opcode, funct3, funct7, rd, m_exe_e, m_exe_m, m_exe_w);
            end
        end
    endtask

    // called on a falling edge once inputs are set
    task automatic next_cycle();
        #5;
        check_outputs();
        @(posedge clk);
        update_model();
        @(negedge clk);
    endtask

    task automatic all_ready();
        de_rdy  = 1'b1;
        exe_rdy = 1'b1;
        mem_rdy = 1'b1;
        wb_rdy  = 1'b1;
    endtask

    task automatic rand_inputs();
        int pick;
        pick = $urandom_range(9, 0);
        // pick 9 gives any 7-bit opcode and mostly an unknown one
        opcode   = (pick == 9) ? opcode_t'(7'($urandom)) : legal_ops[pick];
        funct3   = 3'($urandom);
        funct7   = ($urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
        rd       = 5'($urandom);
        de_valid = ($urandom_range(3, 0) != 0);
        de_rdy   = ($urandom_range(5, 0) != 0);
        exe_rdy  = ($urandom_range(5, 0) != 0);
        mem_rdy  = ($urandom_range(5, 0) != 0);
        wb_rdy   = ($urandom_range(5, 0) != 0);
        br_en    = 1'($urandom);
    endtask

    // run with everything ready until all three stages hold valid words
    task automatic fill_pipe();
        int n;
        all_ready();
        de_valid = 1'b1;
        n = 0;
        while (!(exe_valid && mem_valid && wb_valid) && n < FILL_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!(exe_valid && mem_valid && wb_valid)) begin
            $display("timeout: pipeline did not fill within %0d cycles", FILL_LIMIT);
            show_fail();
            $fatal(1, "pipeline fill timeout");
        end
    endtask

    // stage 0 is de, 1 exe, 2 mem and 3 wb
    task automatic stall_run(input int stage);
        fill_pipe();
        case (stage)
            0: de_rdy = 1'b0;
            1: exe_rdy = 1'b0;
            2: mem_rdy = 1'b0;
            default: wb_rdy = 1'b0;
        endcase
        repeat (3) begin
            opcode = legal_ops[$urandom_range(8, 0)];
            rd     = 5'($urandom);
            next_cycle();
        end
        all_ready();
        next_cycle();
    endtask

    task automatic pc_run(input opcode_t op, input logic br_val);
        all_ready();
        de_valid = 1'b1;
        opcode   = op;
        br_en    = br_val;
        next_cycle();
        // op now sits in exe so the following check sees its PC select
        de_valid = 1'b0;
        next_cycle();
    endtask

    initial begin
        run_ok     = 1'b0;
        fail_shown = 1'b0;
        void'($urandom(32'h8ac2));
        legal_ops  = '{op_lui, op_auipc, op_jal, op_jalr, op_br,
                       op_load, op_store, op_imm, op_reg};
        rst      = 1'b1;
        opcode   = op_lui;
        funct3   = '0;
        funct7   = '0;
        rd       = '0;
        de_valid = 1'b0;
        br_en    = 1'b0;
        all_ready();
        next_cycle();
        next_cycle();
        rst = 1'b0;
        next_cycle();

        // every opcode with every funct3 and both funct7 bit 5 values
        de_valid = 1'b1;
        foreach (legal_ops[i]) begin
            for (int f = 0; f < 16; f++) begin
                opcode = legal_ops[i];
                funct3 = 3'(f);
                funct7 = f[3] ? 7'h20 : 7'h00;
                rd     = 5'(f + i);
                next_cycle();
            end
        end
        opcode = opcode_t'(7'h7f);
        next_cycle();
        de_valid = 1'b0;
        repeat (3) next_cycle();

        for (int s = 0; s < 4; s++) begin
            stall_run(s);
        end

        pc_run(op_jal, 1'b0);
        pc_run(op_jalr, 1'b0);
        pc_run(op_br, 1'b1);
        pc_run(op_br, 1'b0);
        next_cycle();

        repeat (RAND_CYCLES) begin
            rand_inputs();
            next_cycle();
        end

        run_ok = 1'b1;
        $display("Simulation passed");
        $finish;
    end

    // run ended before the whole sequence completed
    final begin
        if (!run_ok) begin
            show_fail();
        end
    end

endmodule

// File: sim.f
source/rv_ctrl_pkg.sv
source/ctrl_word_if.sv
source/instr_decoder.sv
source/stage_ctrl.sv
source/pipe_ctrl_top.sv
verification/pipe_ctrl_sva.sv
verification/pipe_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the control unit testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pipe_ctrl_tb -f sim.f -o pipe_ctrl_sim \
    && { ./obj_dir/pipe_ctrl_sim > sim.log 2>&1; cat sim.log; } \
    && grep -qx "Simulation passed" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
